// File: mesosync_core.f
verilog/mesosync_pkg.sv
verilog/relay_fifo.sv
verilog/credit_fifo.sv
verilog/credit_to_token.sv
verilog/ready_to_credit.sv
verilog/mesosync_core.sv
dv/mesosync_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := mesosync_core_tb
FILELIST := mesosync_core.f
PASS_MSG := all tests passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: dv/mesosync_core_tb.sv
// far end is a behavioral credit model; rows switch loopback only after the link has drained
`timescale 1ns/1ps

module mesosync_core_tb;
    import mesosync_pkg::*;

    // one row per test
    typedef struct packed {
        logic             loopback;
        logic [7:0]       line_pat;
        int               words;
        logic             backpressure;
        logic [WIDTH-1:0] first;
    } row_t;

    logic             clk_i = 1'b0;
    logic             rst_i;
    logic             loopback_en_i;
    logic             line_ready_i;
    logic [WIDTH-1:0] meso_data_i;
    logic             meso_v_i;
    logic             meso_token_i;
    logic [WIDTH-1:0] data_i;
    logic             v_i;
    logic             ready_i;
    logic             meso_token_o;
    logic             meso_v_o;
    logic [WIDTH-1:0] meso_data_o;
    logic             ready_o;
    logic             v_o;
    logic [WIDTH-1:0] data_o;

    row_t        rows [6];
    logic [15:0] lfsr_state;
    logic [2:0]  pat_pos;
    logic        prev_line_ready;
    logic        hold_tokens;
    int          tx_idx;
    int          rx_idx;
    int          out_idx;
    int          far_idx;
    int          far_credit;
    int          far_sent_total;
    int          sent_total;
    int          tokens_given;
    int          watch_cycles;

    mesosync_core dut (.*);

    always #50 clk_i = ~clk_i;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                              input logic [WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    // far end words are complemented so the two streams never look alike
    function automatic logic [WIDTH-1:0] far_word(input int r, input int idx);
        return ~WIDTH'(rows[r].first + idx);
    endfunction

    function automatic logic row_is_done(input int r);
        logic core_side;
        core_side = rows[r].loopback || (tx_idx == rows[r].words && rx_idx == rows[r].words);
        return core_side && out_idx == rows[r].words && far_idx == rows[r].words
            && !hold_tokens && tokens_given == sent_total / DECIMATION
            && far_credit == FIFO_ELS - far_sent_total % DECIMATION;
    endfunction

    // drive on the falling edge, then look at the settled handshakes
    task automatic run_cycle(input int r);
        logic gap_bit;
        logic bp_bit;
        logic tok_now;
        @(negedge clk_i);
        pat_pos       = pat_pos + 3'd1;
        loopback_en_i = rows[r].loopback;
        line_ready_i  = rows[r].line_pat[pat_pos];
        v_i           = !rows[r].loopback && (tx_idx < rows[r].words);
        data_i        = WIDTH'(rows[r].first + tx_idx);
        take_bit(gap_bit);
        // far end only sends while it holds a credit
        meso_v_i    = (far_idx < rows[r].words) && (far_credit > 0) && gap_bit;
        meso_data_i = far_word(r, far_idx);
        take_bit(bp_bit);
        ready_i = rows[r].backpressure ? bp_bit : 1'b1;
        // one token back per DECIMATION words received
        tok_now      = !hold_tokens && (sent_total / DECIMATION > tokens_given);
        meso_token_i = tok_now;
        #1;
        if (v_i && ready_o) begin
            tx_idx++;
        end
        if (!line_ready_i) begin
            check_flag("meso_v_o", meso_v_o, 1'b0);
        end
        // token is registered, so it follows the previous cycle's line state
        if (!prev_line_ready) begin
            check_flag("meso_token_o", meso_token_o, 1'b0);
        end
        if (meso_v_o) begin
            if (rows[r].loopback) begin
                check_word("meso_data_o", meso_data_o, far_word(r, out_idx));
            end else begin
                check_word("meso_data_o", meso_data_o, WIDTH'(rows[r].first + out_idx));
            end
            out_idx++;
            sent_total++;
            if (sent_total > CREDIT_INITIAL + DECIMATION * tokens_given) begin
                report_problem("DUT sent a channel word without holding a credit");
            end
        end
        if (tok_now) begin
            tokens_given++;
        end
        if (meso_token_o) begin
            far_credit += DECIMATION;
            if (far_credit > FIFO_ELS) begin
                report_problem("DUT returned more credits than the far end spent");
            end
        end
        if (meso_v_i) begin
            far_credit--;
            far_idx++;
            far_sent_total++;
        end
        if (rows[r].loopback) begin
            check_flag("v_o", v_o, 1'b0);
            check_flag("ready_o", ready_o, 1'b0);
        end else if (v_o && ready_i) begin
            check_word("data_o", data_o, far_word(r, rx_idx));
            rx_idx++;
        end
        prev_line_ready = line_ready_i;
    endtask

    initial begin
        int row_cycles;
        int budget;
        // loopback, line pattern, words, back-pressure, first word
        rows[0] = '{1'b0, 8'hFF, 10, 1'b0, 16'h1000};
        rows[1] = '{1'b0, 8'hFF, 24, 1'b1, 16'hA5F0};
        rows[2] = '{1'b1, 8'hFF, 12, 1'b0, 16'h3C00};
        rows[3] = '{1'b0, 8'b1110_0000, 16, 1'b1, 16'hFFF8};
        rows[4] = '{1'b1, 8'b0000_1111, 9, 1'b1, 16'h0777};
        rows[5] = '{1'b0, 8'hFF, 7, 1'b0, 16'h5500};
        rst_i = 1'b1;
        loopback_en_i = 1'b0;
        line_ready_i = 1'b0;
        meso_data_i = '0;
        meso_v_i = 1'b0;
        meso_token_i = 1'b0;
        data_i = '0;
        v_i = 1'b0;
        ready_i = 1'b0;
        // seed folded into the 16-bit register
        lfsr_state = 16'(73584);
        pat_pos = 3'd0;
        prev_line_ready = 1'b0;
        hold_tokens = 1'b1;
        far_credit = FIFO_ELS;
        far_sent_total = 0;
        sent_total = 0;
        tokens_given = 0;
        budget = 0;
        for (int r = 0; r < $size(rows); r++) begin
            budget += 20 * rows[r].words + 100;
        end
        watch_cycles = budget;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        #1;
        check_flag("v_o", v_o, 1'b0);
        check_flag("ready_o", ready_o, 1'b0);
        check_flag("meso_v_o", meso_v_o, 1'b0);
        check_flag("meso_token_o", meso_token_o, 1'b0);
        for (int r = 0; r < $size(rows); r++) begin
            tx_idx = 0;
            rx_idx = 0;
            out_idx = 0;
            far_idx = 0;
            row_cycles = 0;
            while (!row_is_done(r)) begin
                run_cycle(r);
                row_cycles++;
                // first row withholds tokens, so only the reset credits can go out
                if (hold_tokens && row_cycles == 30) begin
                    if (sent_total != CREDIT_INITIAL) begin
                        report_problem("channel words before the first token were not 4");
                    end
                    hold_tokens = 1'b0;
                end
            end
        end
        $display("all tests passed");
        $finish;
    end

    // generous bound of 20 cycles per word plus 100 per row
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles + 10) @(posedge clk_i);
        $display("watchdog expired: run did not finish within %0d cycles", watch_cycles);
        stop_run();
    end

endmodule

// File: verilog/mesosync_core.sv
// loopback_en_i is static and may change only while the link is idle; channel sampling lives outside
`timescale 1ns/1ps

module mesosync_core (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             loopback_en_i,
    input  logic                             line_ready_i,

    // channel side
    input  logic [mesosync_pkg::WIDTH-1:0]   meso_data_i,
    input  logic                             meso_v_i,
    output logic                             meso_token_o,
    output logic                             meso_v_o,
    output logic [mesosync_pkg::WIDTH-1:0]   meso_data_o,
    input  logic                             meso_token_i,

    // core side
    input  logic [mesosync_pkg::WIDTH-1:0]   data_i,
    input  logic                             v_i,
    output logic                             ready_o,
    output logic                             v_o,
    output logic [mesosync_pkg::WIDTH-1:0]   data_o,
    input  logic                             ready_i
);
    import mesosync_pkg::*;

    logic             in_relay_v_i;
    logic             in_relay_ready_o;
    logic             in_relay_v_o;
    logic [WIDTH-1:0] in_relay_data_o;
    logic             in_relay_ready_i;
    logic             out_relay_v_i;
    logic             out_relay_ready_o;
    logic             fifo_v;
    logic [WIDTH-1:0] fifo_data;
    logic             fifo_yumi;
    logic             fifo_credit;
    logic             src_v;
    logic             counter_v_i;
    logic             counter_ready;
    logic             send_ready;
    logic             consumer_ready;

    // core side held idle during loopback
    assign in_relay_v_i = v_i & ~loopback_en_i;
    assign ready_o      = in_relay_ready_o & ~loopback_en_i;

    relay_fifo input_relay (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (in_relay_v_i),
        .data_i  (data_i),
        .ready_o (in_relay_ready_o),
        .v_o     (in_relay_v_o),
        .data_o  (in_relay_data_o),
        .ready_i (in_relay_ready_i)
    );

    // sender source: core words normally, FIFO words in loopback
    assign src_v       = loopback_en_i ? fifo_v : in_relay_v_o;
    assign meso_data_o = loopback_en_i ? fifo_data : in_relay_data_o;

    // nothing goes onto the channel while the line is not ready
    assign counter_v_i = line_ready_i & src_v;
    assign send_ready  = line_ready_i & counter_ready;

    ready_to_credit output_credit (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (counter_v_i),
        .ready_o (counter_ready),
        .v_o     (meso_v_o),
        .token_i (meso_token_i)
    );

    assign in_relay_ready_i = send_ready & ~loopback_en_i;

    credit_fifo input_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .v_i      (meso_v_i),
        .data_i   (meso_data_i),
        .credit_o (fifo_credit),
        .v_o      (fifo_v),
        .data_o   (fifo_data),
        .yumi_i   (fifo_yumi)
    );

    // FIFO consumer: output relay normally, the channel sender in loopback
    assign consumer_ready = loopback_en_i ? send_ready : out_relay_ready_o;
    // valid-and-ready to yumi
    assign fifo_yumi      = fifo_v & consumer_ready;

    // tokens share the line with data, so same gate
    credit_to_token token_gen (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .credit_i (fifo_credit),
        .ready_i  (line_ready_i),
        .token_o  (meso_token_o)
    );

    assign out_relay_v_i = fifo_v & ~loopback_en_i;

    relay_fifo output_relay (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (out_relay_v_i),
        .data_i  (fifo_data),
        .ready_o (out_relay_ready_o),
        .v_o     (v_o),
        .data_o  (data_o),
        .ready_i (ready_i)
    );

    // Loopback traffic never leaks to the core, given the mode changes only when idle
    assert property (@(posedge clk_i) disable iff (rst_i) loopback_en_i |-> !v_o);

endmodule

// File: verilog/ready_to_credit.sv
// send-side credit counter; v_o depends combinationally on v_i, token refills saturate at CREDIT_MAX
`timescale 1ns/1ps

module ready_to_credit (
    input  logic clk_i,
    input  logic rst_i,
    input  logic v_i,
    output logic ready_o,
    output logic v_o,
    input  logic token_i
);
    import mesosync_pkg::*;

    logic [CREDIT_W-1:0] count_r;
    logic [CREDIT_W:0]   count_raw;
    logic [CREDIT_W:0]   refill;
    logic                send;

    // any credit left means a word may go
    assign ready_o = (count_r != '0);
    assign send    = v_i & ready_o;
    assign v_o     = send;

    assign refill = token_i ? (CREDIT_W + 1)'(DECIMATION) : '0;

    // send and token in the same cycle net out here
    // no underflow, a send needs a nonzero count
    assign count_raw = {1'b0, count_r} + refill - (CREDIT_W + 1)'(send);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_r <= CREDIT_W'(CREDIT_INITIAL);
        end else if (count_raw > (CREDIT_W + 1)'(CREDIT_MAX)) begin
            count_r <= CREDIT_W'(CREDIT_MAX);
        end else begin
            count_r <= CREDIT_W'(count_raw);
        end
    end

    // the far end must not hand back more than was spent
    // saturation should never actually clip
    assert property (@(posedge clk_i) disable iff (rst_i) count_raw <= CREDIT_MAX);

endmodule

// File: verilog/credit_to_token.sv
// batches credits into tokens; leftover credits below DECIMATION wait until more arrive
`timescale 1ns/1ps

module credit_to_token (
    input  logic clk_i,
    input  logic rst_i,
    input  logic credit_i,
    input  logic ready_i,
    output logic token_o
);
    import mesosync_pkg::*;

    logic [CREDIT_W-1:0] count_r;
    logic [CREDIT_W:0]   sum;
    logic [CREDIT_W:0]   count_next;
    logic                spend;
    logic                token_r;

    // count including a credit arriving this cycle
    assign sum = {1'b0, count_r} + (CREDIT_W + 1)'(credit_i);

    // token only goes out while the line can carry it
    assign spend = ready_i && (sum >= (CREDIT_W + 1)'(DECIMATION));

    always_comb begin
        count_next = sum;
        if (spend) begin
            count_next = sum - (CREDIT_W + 1)'(DECIMATION);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_r <= '0;
            token_r <= 1'b0;
        end else begin
            count_r <= CREDIT_W'(count_next);
            token_r <= spend;
        end
    end

    // registered, one cycle per batch
    assign token_o = token_r;

    // holds only if the far end stays within its credits
    assert property (@(posedge clk_i) disable iff (rst_i) count_r <= CREDIT_MAX);

endmodule

// File: verilog/credit_fifo.sv
// receive FIFO with no back-pressure; the sender must never exceed FIFO_ELS words in flight
`timescale 1ns/1ps

module credit_fifo (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             v_i,
    input  logic [mesosync_pkg::WIDTH-1:0]   data_i,
    output logic                             credit_o,
    output logic                             v_o,
    output logic [mesosync_pkg::WIDTH-1:0]   data_o,
    input  logic                             yumi_i
);
    import mesosync_pkg::*;

    logic [WIDTH-1:0]      mem [FIFO_ELS];
    logic [PTR_W-1:0]      wr_ptr_r;
    logic [PTR_W-1:0]      rd_ptr_r;
    logic [FIFO_CNT_W-1:0] count_r;
    logic                  credit_r;
    logic                  full;
    logic                  empty;

    // wrap explicitly so a depth that is not a power of two also works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(FIFO_ELS - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty = (count_r == '0);
    assign full  = (count_r == FIFO_CNT_W'(FIFO_ELS));

    // head of the ring is always presented
    assign v_o    = ~empty;
    assign data_o = mem[rd_ptr_r];

    // storage written on every accepted channel word
    always_ff @(posedge clk_i) begin
        if (v_i) begin
            mem[wr_ptr_r] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
            credit_r <= 1'b0;
        end else begin
            if (v_i) begin
                wr_ptr_r <= next_ptr(wr_ptr_r);
            end
            if (yumi_i) begin
                rd_ptr_r <= next_ptr(rd_ptr_r);
            end
            case ({v_i, yumi_i})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            // one credit back per dequeued word, a cycle late
            credit_r <= yumi_i;
        end
    end

    assign credit_o = credit_r;

    // far end sent without a credit
    assert property (@(posedge clk_i) disable iff (rst_i) v_i |-> !full);

    // consumer took a word that was not there
    assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> !empty);

endmodule

// File: verilog/relay_fifo.sv
// two-entry skid buffer; ready_o and v_o are flops, so they are low during reset and one cycle after
`timescale 1ns/1ps

module relay_fifo (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             v_i,
    input  logic [mesosync_pkg::WIDTH-1:0]   data_i,
    output logic                             ready_o,
    output logic                             v_o,
    output logic [mesosync_pkg::WIDTH-1:0]   data_o,
    input  logic                             ready_i
);
    import mesosync_pkg::*;

    // two payload slots, used as a tiny ring
    logic [WIDTH-1:0] mem [2];
    logic             wr_ptr_r;
    logic             rd_ptr_r;
    logic [1:0]       count_r;
    logic [1:0]       count_next;
    logic             ready_r;
    logic             v_r;
    logic             enq;
    logic             deq;

    // handshakes only ever look at registered state
    assign enq = v_i & ready_r;
    assign deq = v_r & ready_i;

    always_comb begin
        count_next = count_r;
        if (enq && !deq) begin
            count_next = count_r + 2'd1;
        end else if (deq && !enq) begin
            count_next = count_r - 2'd1;
        end
    end

    // payload slots have no reset
    always_ff @(posedge clk_i) begin
        if (enq) begin
            mem[wr_ptr_r] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
            count_r  <= 2'd0;
            ready_r  <= 1'b0;
            v_r      <= 1'b0;
        end else begin
            wr_ptr_r <= wr_ptr_r ^ enq;
            rd_ptr_r <= rd_ptr_r ^ deq;
            count_r  <= count_next;
            // room left once at most one slot is busy
            ready_r  <= (count_next != 2'd2);
            v_r      <= (count_next != 2'd0);
        end
    end

    assign ready_o = ready_r;
    assign v_o     = v_r;
    assign data_o  = mem[rd_ptr_r];

    // a stalled word must not change under the consumer
    assert property (@(posedge clk_i) disable iff (rst_i)
        (v_o && !ready_i) |=> $stable(data_o));

endmodule

// File: verilog/mesosync_pkg.sv
// one channel only; FIFO_ELS and CREDIT_MAX must both be at least DECIMATION, CREDIT_INITIAL <= CREDIT_MAX
package mesosync_pkg;

    // bits in one data word, same on the core side and on the channel
    localparam int WIDTH = 16;

    // entries in the receive FIFO
    // the far end starts with exactly this many credits
    localparam int FIFO_ELS = 4;

    // credits held by the send-side counter right after reset
    localparam int CREDIT_INITIAL = 4;

    // ceiling for the send counter and the token accumulator
    localparam int CREDIT_MAX = 4;

    // credits represented by a single token pulse
    localparam int DECIMATION = 2;

    // credit counters must be able to hold CREDIT_MAX itself
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

    // read and write pointers into the receive FIFO
    // a one-entry FIFO still needs a 1-bit pointer
    localparam int PTR_W = (FIFO_ELS > 1) ? $clog2(FIFO_ELS) : 1;

    // occupancy counter of the receive FIFO, counts 0..FIFO_ELS
    localparam int FIFO_CNT_W = $clog2(FIFO_ELS + 1);

endpackage
